//--- test/histTestdata.txt
// word 0 sample count, word 1 record count; timestamps from 010, 32 per phase in sweep order
// records from 100 as hex digits: phase, pixel, bin, then two count digits
@000
00080 00010
@010
// frame 1 coarse
32 35 71 38 A1 52 A4 55
01 0C 05 E0 F0 F8 FE 44
3A 72 3F 10 5F AA 20 2F
09 0F 81 E3 F3 44 45 90
// frame 1 fine
2B 30 27 30 4C 50 4C 58
00 10 0F 0F E8 F7 F8 E7
38 37 30 2B 47 50 4C 57
02 FF 0F 00 E9 E9 F7 E9
// frame 2 coarse
71 72 73 30 C0 C1 C2 C3
E0 0E E5 E9 20 21 22 F0
74 10 11 12 C4 C5 C6 C7
81 82 83 84 F1 F2 23 24
// frame 2 fine
68 77 78 6A C7 C7 C7 C7
79 80 81 79 18 19 1A 1B
6A 6A 67 70 C7 C7 B8 C8
80 79 7F 00 1C 1D 1E 1F
@100
// expected peaks in report order
00305 01503 02005 03F04
10803 11403 12F03 13103
00704 01C08 02804 03205
10203 11F06 12103 13001

//--- all.f
hdl/histPkg.sv
hdl/sampleSequencer.sv
hdl/windowRegs.sv
hdl/binMapper.sv
hdl/histogramMemory.sv
hdl/peakTracker.sv
hdl/histogramTop.sv
test/histogramTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= histogramTb
FILELIST ?= all.f
OBJDIR ?= obj_dir
LOG ?= sim.log
DATA ?= test/histTestdata.txt
VFLAGS ?= --binary --assert

SRCS := $(wildcard hdl/*.sv test/*.sv)
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- test/histogramTb.sv
`timescale 1ns/1ps
`default_nettype none

module histogramTb
    import histPkg::*;
();

    localparam int samplesPhase = pixelNum * samplesPerPixel * acqNum;
    localparam int sampleBase = 'h10;     // word address of the first timestamp
    localparam int peakBase = 'h100;      // word address of the first peak record
    localparam int idleAfterPhase = 8;

    logic clk;
    logic combin_res;
    logic wrEn;
    timestampT timestamp;
    phaseT phase;
    logic peakValid;
    phaseT peakPhase;
    pixelT peakPixel;
    binT peakBin;
    countT peakCount;

    logic [19:0] dataMem [0:511];
    int sampleNum = 0;
    int peakNum = 0;
    int timeoutLimit = 0;
    int cycleCnt = 0;
    int monCycle = 0;
    int lastWrCycle = -100;              // negedge count of the last sample of a phase
    int seenSamples = 0;
    int peakIdx = 0;
    int mismatchCnt = 0;
    int otherCnt = 0;
    logic [31:0] rngState = 32'd90780;

    histogramTop dut_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .timestamp  (timestamp),
        .phase      (phase),
        .peakValid  (peakValid),
        .peakPhase  (peakPhase),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic flagMismatch(input string sigName, input int expVal, input int actVal);
        mismatchCnt++;
        $display("mismatch at %0t: %s expected %0d, got %0d", $time, sigName, expVal, actVal);
    endtask

    // compare one report pulse with the next record
    task automatic checkPeak();
        logic [19:0] rec;
        int offset;
        logic inReport;
        phaseT expPhase;
        pixelT expPixel;
        binT expBin;
        countT expCount;
        offset = monCycle - lastWrCycle - 2;   // pixel 0 is due 2 cycles after the last sample
        inReport = (peakIdx < peakNum) && (offset >= 0) && (offset < pixelNum);
        assert (inReport) else begin
            otherCnt++;
            $display("unexpected peak report at %0t for pixel %0d", $time, int'(peakPixel));
        end
        if (inReport) begin
            rec = dataMem[peakBase + peakIdx];
            expPhase = rec[16] ? finePhase : coarsePhase;
            expPixel = pixelT'(rec[13:12]);
            expBin = binT'(rec[11:8]);
            expCount = countT'(rec[7:0]);
            assert (offset == int'(expPixel)) else begin
                otherCnt++;
                $display("report for pixel %0d came %0d cycles after the last sample, not %0d",
                         int'(expPixel), offset + 2, int'(expPixel) + 2);
            end
            assert (peakPhase == expPhase)
                else flagMismatch("peakPhase", int'(expPhase), int'(peakPhase));
            assert (peakPixel == expPixel)
                else flagMismatch("peakPixel", int'(expPixel), int'(peakPixel));
            assert (peakBin == expBin)
                else flagMismatch("peakBin", int'(expBin), int'(peakBin));
            assert (peakCount == expCount)
                else flagMismatch("peakCount", int'(expCount), int'(peakCount));
            peakIdx++;
        end
    endtask

    // outputs are sampled on the falling edge
    always @(negedge clk) begin
        phaseT expPhase;
        if (combin_res) begin
            monCycle++;
            expPhase = ((seenSamples / samplesPhase) % 2 == 1) ? finePhase : coarsePhase;
            assert (phase == expPhase)
                else flagMismatch("phase", int'(expPhase), int'(phase));
            if (peakValid) begin
                checkPeak();
            end
            if (wrEn) begin
                seenSamples++;
                if (seenSamples % samplesPhase == 0) begin
                    lastWrCycle = monCycle;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (timeoutLimit > 0 && cycleCnt >= timeoutLimit) begin
            $display("timeout: run stopped after %0d cycles", cycleCnt);
            $display("errors: %0d mismatch, %0d other", mismatchCnt, otherCnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        int idle;
        logic fileOk;
        clk = 1'b0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        timestamp = '0;
        $readmemh("test/histTestdata.txt", dataMem);
        fileOk = !$isunknown(dataMem[0]) && !$isunknown(dataMem[1]);
        assert (fileOk) else begin
            otherCnt++;
            $display("test data file could not be read");
        end
        if (fileOk) begin
            sampleNum = int'(dataMem[0]);
            peakNum = int'(dataMem[1]);
        end
        // up to 3 cycles per sample plus the idle gap of every phase
        timeoutLimit = 4 * (3 * sampleNum
                            + (idleAfterPhase + 1) * (sampleNum / samplesPhase) + 4);

        repeat (2) @(posedge clk);
        combin_res <= 1'b1;

        // a bin gets at most 8 hits per phase here, so counts never reach saturation
        for (int i = 0; i < sampleNum; i++) begin
            rngState = xorshift32(rngState);
            idle = int'(rngState % 32'd3);
            repeat (idle) begin
                @(posedge clk);
                wrEn <= 1'b0;
            end
            @(posedge clk);
            wrEn <= 1'b1;
            timestamp <= timestampT'(dataMem[sampleBase + i]);
            if ((i + 1) % samplesPhase == 0) begin
                @(posedge clk);
                wrEn <= 1'b0;                          // quiet while the peaks go out
                repeat (idleAfterPhase) @(posedge clk);
            end
        end

        repeat (4) @(posedge clk);
        assert (peakIdx == peakNum) else begin
            otherCnt++;
            $display("missing peak reports: %0d of %0d seen", peakIdx, peakNum);
        end
        $display("errors: %0d mismatch, %0d other", mismatchCnt, otherCnt);
        if (mismatchCnt == 0 && otherCnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/histogramTop.sv
`timescale 1ns/1ps
`default_nettype none

module histogramTop
    import histPkg::*;
(
    input  wire logic  clk,
    input  wire logic  combin_res,
    input  wire logic  wrEn,
    input  timestampT  timestamp,
    output phaseT      phase,
    output logic       peakValid,
    output phaseT      peakPhase,
    output pixelT      peakPixel,
    output binT        peakBin,
    output countT      peakCount
);

    pixelT curPixel;
    logic lastSample;
    timestampT winStart;
    binT binIdx;
    logic inWindow;
    logic countValid;
    pixelT countPixel;
    binT countBin;
    countT newCount;
    logic histClear;
    logic winLoad;

    // only coarse peaks place the fine windows
    assign winLoad = peakValid && (peakPhase == coarsePhase);

    sampleSequencer seq_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .curPixel   (curPixel),
        .phase      (phase),
        .lastSample (lastSample)
    );

    windowRegs win_i (
        .clk        (clk),
        .combin_res (combin_res),
        .loadEn     (winLoad),
        .loadPixel  (peakPixel),
        .loadBin    (peakBin),
        .readPixel  (curPixel),
        .winStart   (winStart)
    );

    binMapper map_i (
        .phase      (phase),
        .timestamp  (timestamp),
        .winStart   (winStart),
        .binIdx     (binIdx),
        .inWindow   (inWindow)
    );

    histogramMemory mem_i (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .inWindow   (inWindow),
        .curPixel   (curPixel),
        .binIdx     (binIdx),
        .histClear  (histClear),
        .countValid (countValid),
        .countPixel (countPixel),
        .countBin   (countBin),
        .newCount   (newCount)
    );

    peakTracker peak_i (
        .clk        (clk),
        .combin_res (combin_res),
        .countValid (countValid),
        .countPixel (countPixel),
        .countBin   (countBin),
        .newCount   (newCount),
        .phaseEnd   (lastSample),
        .phase      (phase),
        .peakValid  (peakValid),
        .peakPhase  (peakPhase),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .histClear  (histClear)
    );

endmodule

`default_nettype wire

//--- hdl/peakTracker.sv
`timescale 1ns/1ps
`default_nettype none

module peakTracker
    import histPkg::*;
(
    input  wire logic  clk,
    input  wire logic  combin_res,
    input  wire logic  countValid,
    input  pixelT      countPixel,
    input  binT        countBin,
    input  countT      newCount,
    input  wire logic  phaseEnd,
    input  phaseT      phase,
    output logic       peakValid,
    output phaseT      peakPhase,
    output pixelT      peakPixel,
    output binT        peakBin,
    output countT      peakCount,
    output logic       histClear
);

    countT maxCount [pixelNum];
    binT maxBin [pixelNum];

    logic phaseEndD;           // waits for the final count
    phaseT rptPhase;
    logic rptActive;
    pixelT rptIdx;
    logic rptLast;

    assign rptLast = rptActive && (rptIdx == pixelT'(pixelNum - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            phaseEndD <= 1'b0;
            rptPhase <= coarsePhase;
            rptActive <= 1'b0;
            rptIdx <= '0;
        end else begin
            phaseEndD <= phaseEnd;
            if (phaseEnd) begin
                rptPhase <= phase;    // still the ending phase here
            end
            if (phaseEndD) begin
                rptActive <= 1'b1;
                rptIdx <= '0;
            end else if (rptLast) begin
                rptActive <= 1'b0;
            end else if (rptActive) begin
                rptIdx <= rptIdx + 1'b1;
            end
        end
    end

    // strict compare keeps the first bin on a tie
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < pixelNum; i++) begin
                maxCount[i] <= '0;
                maxBin[i] <= '0;
            end
        end else if (rptLast) begin
            for (int i = 0; i < pixelNum; i++) begin
                maxCount[i] <= '0;
                maxBin[i] <= '0;
            end
        end else if (countValid && (newCount > maxCount[countPixel])) begin
            maxCount[countPixel] <= newCount;
            maxBin[countPixel] <= countBin;
        end
    end

    assign peakValid = rptActive;
    assign peakPhase = rptPhase;
    assign peakPixel = rptIdx;
    assign peakBin = maxBin[rptIdx];
    assign peakCount = maxCount[rptIdx];
    assign histClear = rptLast;   // memory empties with the last report

endmodule

`default_nettype wire

//--- hdl/histogramMemory.sv
`timescale 1ns/1ps
`default_nettype none

module histogramMemory
    import histPkg::*;
(
    input  wire logic  clk,
    input  wire logic  combin_res,
    input  wire logic  wrEn,
    input  wire logic  inWindow,
    input  pixelT      curPixel,
    input  binT        binIdx,
    input  wire logic  histClear,
    output logic       countValid,
    output pixelT      countPixel,
    output binT        countBin,
    output countT      newCount
);

    localparam int entryNum = binNum * pixelNum;

    countT countArr [entryNum];
    logic [entryNum-1:0] validBits;   // entry holds a count of this frame

    memAddrT addr;
    logic wrHit;
    countT oldCount;
    countT incCount;

    assign addr = {curPixel, binIdx};
    assign wrHit = wrEn && inWindow;

    // a stale entry reads as zero
    assign oldCount = validBits[addr] ? countArr[addr] : '0;
    assign incCount = (oldCount == '1) ? oldCount : oldCount + 1'b1;

    always_ff @(posedge clk) begin
        if (wrHit) begin
            countArr[addr] <= incCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            validBits <= '0;
        end else if (histClear) begin
            validBits <= '0;          // whole histogram empty at once
        end else if (wrHit) begin
            validBits[addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            countValid <= 1'b0;
        end else begin
            countValid <= wrHit;
        end
    end

    // updated count goes to the peak tracker
    always_ff @(posedge clk) begin
        if (wrHit) begin
            countPixel <= curPixel;
            countBin <= binIdx;
            newCount <= incCount;
        end
    end

endmodule

`default_nettype wire

//--- hdl/binMapper.sv
`timescale 1ns/1ps
`default_nettype none

module binMapper
    import histPkg::*;
(
    input  phaseT      phase,
    input  timestampT  timestamp,
    input  timestampT  winStart,
    output binT        binIdx,
    output logic       inWindow
);

    timestampT offset;

    // below winStart wraps to a large value, so one compare covers both edges
    assign offset = timestamp - winStart;

    always_comb begin
        if (phase == coarsePhase) begin
            binIdx = timestamp[tsWidth-1 -: binBits];   // top bits only
            inWindow = 1'b1;
        end else begin
            binIdx = offset[binBits-1:0];               // full resolution
            inWindow = (offset < timestampT'(binNum));
        end
    end

endmodule

`default_nettype wire

//--- hdl/windowRegs.sv
`timescale 1ns/1ps
`default_nettype none

module windowRegs
    import histPkg::*;
(
    input  wire logic  clk,
    input  wire logic  combin_res,
    input  wire logic  loadEn,
    input  pixelT      loadPixel,
    input  binT        loadBin,
    input  pixelT      readPixel,
    output timestampT  winStart
);

    timestampT startRegs [pixelNum];

    int rawStart;              // signed, may go below zero
    timestampT clampStart;

    // window centred on the coarse bin, kept inside the timestamp range
    always_comb begin
        rawStart = int'(loadBin) * binNum - halfWindow;
        if (rawStart < 0) begin
            clampStart = '0;
        end else if (rawStart > windowMax) begin
            clampStart = timestampT'(windowMax);
        end else begin
            clampStart = timestampT'(rawStart);
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < pixelNum; i++) begin
                startRegs[i] <= '0;
            end
        end else if (loadEn) begin
            startRegs[loadPixel] <= clampStart;   // held until next coarse report
        end
    end

    assign winStart = startRegs[readPixel];

endmodule

`default_nettype wire

//--- hdl/sampleSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sampleSequencer
    import histPkg::*;
(
    input  wire logic  clk,
    input  wire logic  combin_res,
    input  wire logic  wrEn,
    output pixelT      curPixel,
    output phaseT      phase,
    output logic       lastSample
);

    typedef logic [$clog2(samplesPerPixel)-1:0] sampleCntT;
    typedef logic [$clog2(acqNum)-1:0] acqCntT;

    sampleCntT sampleCnt;
    pixelT pixelCnt;
    acqCntT acqCnt;

    logic sampleWrap;
    logic pixelWrap;
    logic acqWrap;

    assign sampleWrap = (sampleCnt == sampleCntT'(samplesPerPixel - 1));
    assign pixelWrap = (pixelCnt == pixelT'(pixelNum - 1));
    assign acqWrap = (acqCnt == acqCntT'(acqNum - 1));

    // high during the final sample of the phase
    assign lastSample = wrEn && sampleWrap && pixelWrap && acqWrap;

    assign curPixel = pixelCnt;

    // nested counters, sample is innermost
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else if (wrEn) begin
            if (sampleWrap) begin
                sampleCnt <= '0;
                if (pixelWrap) begin
                    pixelCnt <= '0;
                    acqCnt <= acqWrap ? '0 : acqCnt + 1'b1;   // wraps with the phase
                end else begin
                    pixelCnt <= pixelCnt + 1'b1;
                end
            end else begin
                sampleCnt <= sampleCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            phase <= coarsePhase;
        end else if (lastSample) begin
            phase <= (phase == coarsePhase) ? finePhase : coarsePhase;
        end
    end

endmodule

`default_nettype wire

//--- hdl/histPkg.sv
`default_nettype none

package histPkg;

    // timestamp and histogram geometry
    localparam int tsWidth = 8;
    localparam int binBits = 4;
    localparam int binNum = 16;            // bins per pixel histogram

    // sweep shape of one phase
    localparam int pixelNum = 4;
    localparam int samplesPerPixel = 4;
    localparam int acqNum = 2;             // pixel sweeps per phase

    localparam int countWidth = 8;         // counts saturate at all ones

    // fine window placement around a coarse peak
    localparam int halfWindow = 8;
    localparam int windowMax = (2 ** tsWidth) - binNum;

    typedef logic [tsWidth-1:0] timestampT;
    typedef logic [binBits-1:0] binT;
    typedef logic [countWidth-1:0] countT;
    typedef logic [$clog2(pixelNum)-1:0] pixelT;
    typedef logic [$clog2(pixelNum)+binBits-1:0] memAddrT;   // {pixel, bin}

    typedef enum logic {
        coarsePhase = 1'b0,
        finePhase = 1'b1
    } phaseT;

endpackage

`default_nettype wire
